// File: vga_demo_top.f
common/vga_pkg.sv
common/video_if.sv
vga/vga_timing.sv
vga/pattern_gen.sv
rtl/reset_stretch.sv
rtl/frame_leds.sv
rtl/vga_demo_top.sv
test/vga_demo_checker.sv
test/tb_vga_demo.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vga demo testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_vga_demo \
  -Mdir obj_dir -o sim_vga_demo -f vga_demo_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_vga_demo +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$log"; then
  exit 1
fi
if ! grep -q "test passed" "$log"; then
  echo "no result line in $log"
  exit 1
fi
exit 0

// File: test/tb_vga_demo.sv
`timescale 1ns/100ps

module tb_vga_demo;
  import vga_pkg::*;

  localparam int frame_cycles   = h_total * v_total;
  localparam int timeout_cycles = 3 * frame_cycles + 100;
  localparam int drive_delay    = 1;

  logic                 clk_25mhz;
  logic                 rst_n;
  logic [num_leds-1:0]  leds;
  logic [pin_depth-1:0] vga_r;
  logic [pin_depth-1:0] vga_g;
  logic [pin_depth-1:0] vga_b;
  logic                 vga_hs;
  logic                 vga_vs;
  int                   failures;

  vga_demo_top UUT (.*);

  bind vga_demo_top vga_demo_checker u_checker (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .srst_n    (srst_n),
    .leds      (leds),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .vga_hs    (vga_hs),
    .vga_vs    (vga_vs)
  );

  initial begin
    clk_25mhz = 1'b0;
    forever #20 clk_25mhz = ~clk_25mhz;
  end

  task automatic pulse_reset(input int cycles);
    @(posedge clk_25mhz);
    #drive_delay rst_n = 1'b0;
    repeat (cycles) @(posedge clk_25mhz);
    #drive_delay rst_n = 1'b1;
  endtask

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk_25mhz);
    #drive_delay rst_n = 1'b1;
    while (leds != 5'd2) @(negedge clk_25mhz);   // two whole frames seen
    @(negedge vga_vs);
    @(negedge vga_hs);
    pulse_reset(3);   // lands inside both sync pulses
    @(negedge vga_hs);
    repeat (h_total - h_sync_start + 7 * bar_width + bar_width / 2) @(posedge clk_25mhz);
    pulse_reset(3);   // lands in the white bar of line 1
    @(negedge vga_hs);
    repeat (8 * h_total) @(posedge clk_25mhz);
    failures = UUT.u_checker.fail_count;
    $display("closing report: %0d assertion failures", failures);
    if (failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_25mhz);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// File: test/vga_demo_checker.sv
`timescale 1ns/100ps

module vga_demo_checker (
  input logic                          clk_25mhz,
  input logic                          rst_n,
  input logic                          srst_n,
  input logic [vga_pkg::num_leds-1:0]  leds,
  input logic [vga_pkg::pin_depth-1:0] vga_r,
  input logic [vga_pkg::pin_depth-1:0] vga_g,
  input logic [vga_pkg::pin_depth-1:0] vga_b,
  input logic                          vga_hs,
  input logic                          vga_vs
);
  import vga_pkg::*;

  int                   fail_count;
  int                   rst_hi_cnt;
  int                   run_cnt;
  int                   hs_low_cnt;
  int                   vs_low_cnt;
  int                   hs_period;
  int                   vs_period;
  int                   px;
  int                   py;
  int                   cur_x;
  int                   cur_y;
  logic                 armed;
  logic                 rst_q;
  logic                 srst_q;
  logic                 hs_q;
  logic                 vs_q;
  logic                 hs_seen;
  logic                 vs_seen;
  logic                 hs_fall;
  logic                 hs_rise;
  logic                 vs_fall;
  logic                 vs_rise;
  logic                 pos_ok;
  logic                 frame_wrap;
  logic [num_leds-1:0]  leds_q;
  logic [3*pin_depth-1:0] rgb_out;
  logic [3*pin_depth-1:0] rgb_exp;

  task automatic count_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // bar bits 0 to 2 select red, green and blue
  function automatic logic [3*pin_depth-1:0] expected_rgb(input int x, input int y);
    int bar;
    logic [3*pin_depth-1:0] rgb;
    bar = x / bar_width;
    rgb = '0;
    if (x < h_active && y < v_active) begin
      rgb = {{pin_depth{bar[0]}}, {pin_depth{bar[1]}}, {pin_depth{bar[2]}}};
    end
    return rgb;
  endfunction

  always_comb begin
    hs_fall    = hs_q && !vga_hs;
    hs_rise    = !hs_q && vga_hs;
    vs_fall    = vs_q && !vga_vs;
    vs_rise    = !vs_q && vga_vs;
    cur_x      = hs_fall ? h_sync_start : px;   // hs fall shows pixel 656
    cur_y      = vs_fall ? v_sync_start : py;
    pos_ok     = (hs_seen || hs_fall) && (vs_seen || vs_fall);
    frame_wrap = pos_ok && (cur_x == h_total - 1) && (cur_y == v_total - 1);
    rgb_out    = {vga_r, vga_g, vga_b};
    rgb_exp    = expected_rgb(cur_x, cur_y);
  end

  always_ff @(posedge clk_25mhz) begin
    armed  <= 1'b1;
    rst_q  <= rst_n;
    srst_q <= srst_n;
    hs_q   <= vga_hs;
    vs_q   <= vga_vs;
    leds_q <= leds;
    if (!rst_n) begin
      rst_hi_cnt <= 0;
    end else if (rst_hi_cnt < h_total) begin
      rst_hi_cnt <= rst_hi_cnt + 1;
    end
  end

  // shadow position of the pixel now on the pins
  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      px      <= 0;
      py      <= 0;
      hs_seen <= 1'b0;
      vs_seen <= 1'b0;
    end else begin
      hs_seen <= hs_seen || hs_fall;
      vs_seen <= vs_seen || vs_fall;
      if (cur_x == h_total - 1) begin
        px <= 0;
        py <= (cur_y == v_total - 1) ? 0 : cur_y + 1;
      end else begin
        px <= cur_x + 1;
        py <= cur_y;
      end
    end
  end

  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      run_cnt    <= 0;
      hs_low_cnt <= 0;
      vs_low_cnt <= 0;
      hs_period  <= 0;
      vs_period  <= 0;
    end else begin
      run_cnt    <= (run_cnt < h_total) ? run_cnt + 1 : run_cnt;
      hs_low_cnt <= vga_hs ? 0 : hs_low_cnt + 1;
      vs_low_cnt <= vga_vs ? 0 : vs_low_cnt + 1;
      hs_period  <= hs_fall ? 1 : hs_period + 1;
      vs_period  <= vs_fall ? 1 : vs_period + 1;
    end
  end

  reset_state_chk: assert property (@(posedge clk_25mhz)
    armed && !srst_q |-> vga_hs && vga_vs && rgb_out == '0 && leds == '0)
    else count_failure($sformatf(
      "ERROR reset_state: expected hs/vs/rgb/leds 1/1/000/00, actual %b/%b/%h/%h",
      vga_hs, vga_vs, rgb_out, leds));
  reset_entry_chk: assert property (@(posedge clk_25mhz) armed && !rst_q |-> !srst_n)
    else count_failure($sformatf("ERROR reset_entry: expected srst_n 0, actual %b", srst_n));
  reset_hold_chk: assert property (@(posedge clk_25mhz)
    armed && !srst_q && srst_n |-> rst_hi_cnt == reset_hold + 1)   // one extra for the srst_n flop
    else count_failure($sformatf("ERROR reset_hold: expected %0d, actual %0d",
      reset_hold + 1, rst_hi_cnt));
  restart_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    hs_fall && !hs_seen |-> run_cnt == h_sync_start + 1)
    else count_failure($sformatf("ERROR restart: expected %0d, actual %0d",
      h_sync_start + 1, run_cnt));
  hs_width_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    hs_rise && hs_seen |-> hs_low_cnt == h_sync)
    else count_failure($sformatf("ERROR hs_width: expected %0d, actual %0d", h_sync, hs_low_cnt));
  hs_period_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    hs_fall && hs_seen |-> hs_period == h_total)
    else count_failure($sformatf("ERROR hs_period: expected %0d, actual %0d", h_total, hs_period));
  vs_width_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    vs_rise && vs_seen |-> vs_low_cnt == v_sync * h_total)
    else count_failure($sformatf("ERROR vs_width: expected %0d, actual %0d",
      v_sync * h_total, vs_low_cnt));
  vs_period_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    vs_fall && vs_seen |-> vs_period == v_total * h_total)
    else count_failure($sformatf("ERROR vs_period: expected %0d, actual %0d",
      v_total * h_total, vs_period));
  colour_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    pos_ok |-> rgb_out == rgb_exp)
    else count_failure($sformatf("ERROR colour at %0d,%0d: expected %h, actual %h",
      cur_x, cur_y, rgb_exp, rgb_out));
  leds_step_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    frame_wrap |-> leds == leds_q + 1'b1)
    else count_failure($sformatf("ERROR leds_step: expected %h, actual %h", leds_q + 1'b1, leds));
  leds_hold_chk: assert property (@(posedge clk_25mhz) disable iff (!srst_n)
    !frame_wrap |-> leds == leds_q)
    else count_failure($sformatf("ERROR leds_hold: expected %h, actual %h", leds_q, leds));

endmodule

// File: rtl/vga_demo_top.sv
`timescale 1ns/100ps

module vga_demo_top (
  input  logic                          clk_25mhz,
  input  logic                          rst_n,
  output logic [vga_pkg::num_leds-1:0]  leds,
  output logic [vga_pkg::pin_depth-1:0] vga_r,
  output logic [vga_pkg::pin_depth-1:0] vga_g,
  output logic [vga_pkg::pin_depth-1:0] vga_b,
  output logic                          vga_hs,
  output logic                          vga_vs
);
  import vga_pkg::*;

  logic   srst_n;
  color_t red;
  color_t green;
  color_t blue;

  video_if vid ();

  reset_stretch u_reset_stretch (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .srst_n    (srst_n)
  );

  vga_timing u_vga_timing (
    .clk_25mhz (clk_25mhz),
    .srst_n    (srst_n),
    .vid       (vid.source)
  );

  pattern_gen u_pattern_gen (
    .clk_25mhz (clk_25mhz),
    .srst_n    (srst_n),
    .vid       (vid.sink),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hs_out    (vga_hs),
    .vs_out    (vga_vs)
  );

  frame_leds u_frame_leds (
    .clk_25mhz (clk_25mhz),
    .srst_n    (srst_n),
    .vid       (vid.sink),
    .leds      (leds)
  );

  // keep the msbs, the dac has fewer bits than the pattern
  assign vga_r = red[color_depth-1 -: pin_depth];
  assign vga_g = green[color_depth-1 -: pin_depth];
  assign vga_b = blue[color_depth-1 -: pin_depth];

endmodule

// File: rtl/frame_leds.sv
`timescale 1ns/100ps

module frame_leds (
  input  logic                         clk_25mhz,
  input  logic                         srst_n,
  video_if.sink                        vid,
  output logic [vga_pkg::num_leds-1:0] leds
);
  import vga_pkg::*;

  logic [num_leds-1:0] frame_cnt;

  // wraps every 2^num_leds frames
  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      frame_cnt <= '0;
    end else if (vid.frame_end) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  assign leds = frame_cnt;   // heartbeat for the board

endmodule

// File: rtl/reset_stretch.sv
`timescale 1ns/100ps

module reset_stretch (
  input  logic clk_25mhz,
  input  logic rst_n,
  output logic srst_n
);
  import vga_pkg::*;

  logic [hold_w-1:0] hold_cnt;

  // reload while the board reset is held, then run down
  always_ff @(posedge clk_25mhz) begin
    if (!rst_n) begin
      hold_cnt <= hold_w'(reset_hold);
      srst_n   <= 1'b0;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end
      srst_n <= (hold_cnt == '0);   // release only once drained
    end
  end

endmodule

// File: vga/pattern_gen.sv
`timescale 1ns/100ps

module pattern_gen (
  input  logic            clk_25mhz,
  input  logic            srst_n,
  video_if.sink           vid,
  output vga_pkg::color_t red,
  output vga_pkg::color_t green,
  output vga_pkg::color_t blue,
  output logic            hs_out,
  output logic            vs_out
);
  import vga_pkg::*;

  logic [bar_idx_w-1:0] bar;
  color_t               red_d;
  color_t               green_d;
  color_t               blue_d;

  // bar index from x, only meaningful inside the active area
  assign bar = bar_idx_w'(vid.x / bar_width);

  always_comb begin
    red_d   = color_off;
    green_d = color_off;
    blue_d  = color_off;
    if (vid.active) begin
      if (bar[0]) begin
        red_d = color_max;
      end
      if (bar[1]) begin
        green_d = color_max;
      end
      if (bar[2]) begin
        blue_d = color_max;
      end
    end
  end

  // colour and sync share one register stage
  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      red    <= color_off;
      green  <= color_off;
      blue   <= color_off;
      hs_out <= 1'b1;   // inactive
      vs_out <= 1'b1;
    end else begin
      red    <= red_d;
      green  <= green_d;
      blue   <= blue_d;
      hs_out <= vid.hs;
      vs_out <= vid.vs;
    end
  end

endmodule

// File: vga/vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
  input  logic    clk_25mhz,
  input  logic    srst_n,
  video_if.source vid
);
  import vga_pkg::*;

  pos_x_t h_cnt;
  pos_y_t v_cnt;
  logic   h_last;
  logic   v_last;
  logic   h_vis;
  logic   v_vis;
  logic   h_pulse;
  logic   v_pulse;

  assign h_last = (h_cnt == pos_x_t'(h_total - 1));
  assign v_last = (v_cnt == pos_y_t'(v_total - 1));

  // horizontal counter, wraps every line
  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      h_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // vertical counter, steps on horizontal wrap
  always_ff @(posedge clk_25mhz) begin
    if (!srst_n) begin
      v_cnt <= '0;
    end else if (h_last) begin
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end
  end

  // window decode from the counter values
  always_comb begin
    h_vis   = (h_cnt < pos_x_t'(h_active));
    v_vis   = (v_cnt < pos_y_t'(v_active));
    h_pulse = (h_cnt >= pos_x_t'(h_sync_start)) && (h_cnt < pos_x_t'(h_sync_end));
    v_pulse = (v_cnt >= pos_y_t'(v_sync_start)) && (v_cnt < pos_y_t'(v_sync_end));
  end

  assign vid.x         = h_cnt;
  assign vid.y         = v_cnt;
  assign vid.active    = h_vis && v_vis;
  assign vid.hs        = !h_pulse;   // negative polarity for 640x480
  assign vid.vs        = !v_pulse;
  assign vid.frame_end = h_last && v_last;

endmodule

// File: common/video_if.sv
`timescale 1ns/100ps

interface video_if;
  import vga_pkg::*;

  pos_x_t x;
  pos_y_t y;
  logic   active;
  logic   hs;          // active low
  logic   vs;          // active low
  logic   frame_end;   // last pixel of the last line

  modport source (
    output x,
    output y,
    output active,
    output hs,
    output vs,
    output frame_end
  );

  modport sink (
    input x,
    input y,
    input active,
    input hs,
    input vs,
    input frame_end
  );

endinterface

// File: common/vga_pkg.sv
package vga_pkg;

  // horizontal timing, pixel clocks
  localparam int h_active = 640;
  localparam int h_front  = 16;
  localparam int h_sync   = 96;
  localparam int h_back   = 48;
  localparam int h_total  = h_active + h_front + h_sync + h_back; // 800

  // vertical timing, lines
  localparam int v_active = 480;
  localparam int v_front  = 10;
  localparam int v_sync   = 2;
  localparam int v_back   = 33;
  localparam int v_total  = v_active + v_front + v_sync + v_back; // 525

  // sync windows, start inclusive and end exclusive
  localparam int h_sync_start = h_active + h_front;
  localparam int h_sync_end   = h_sync_start + h_sync;
  localparam int v_sync_start = v_active + v_front;
  localparam int v_sync_end   = v_sync_start + v_sync;

  localparam int color_depth = 6;
  localparam int pin_depth   = 4;   // pmod dac width

  localparam int bar_width = 80;
  localparam int bar_count = h_active / bar_width;
  localparam int bar_idx_w = $clog2(bar_count);

  localparam int reset_hold = 32;
  localparam int hold_w     = $clog2(reset_hold + 1);

  localparam int num_leds = 5;

  typedef logic [9:0] pos_x_t;
  typedef logic [9:0] pos_y_t;
  typedef logic [color_depth-1:0] color_t;

  localparam color_t color_max = {color_depth{1'b1}};
  localparam color_t color_off = '0;

endpackage
